//--- design/cp0Unit.sv
`timescale 1ns/1ps
`include "memStage_defines.svh"

module cp0Unit (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [31:0]             pc,
    input  logic [5:0]              hwInt,
    input  logic                    branchInWb,
    cp0PortIf.cp0                   cp0Port,
    output memStagePkg::kernelCtrl  kernelCtrl,
    output logic [29:0]             epc,
    output logic                    inDelaySlot
);
    localparam logic [31:0] textStart = `TEXT_START;

    // SR fields
    logic [5:0]          im;
    logic                exl;
    logic                ie;
    // Cause fields
    logic [5:0]          ip;
    memStagePkg::excCode code;
    logic                bd;
    logic [31:2]         epcReg;

    logic                interrupt;
    logic                trap;
    memStagePkg::cp0Word wrWord;
    memStagePkg::cp0Word srWord;
    memStagePkg::cp0Word causeWord;

    assign interrupt = (|(im & hwInt)) && ie && !exl;
    assign trap      = interrupt || (cp0Port.excIn != memStagePkg::excNone);
    assign cp0Port.trap = trap;

    always_comb begin
        if (trap) begin
            kernelCtrl = memStagePkg::kcEnterKernel;
        end else if (cp0Port.eret) begin
            kernelCtrl = memStagePkg::kcReturn;
        end else begin
            kernelCtrl = memStagePkg::kcNone;
        end
    end

    assign inDelaySlot = trap && branchInWb;
    assign epc         = epcReg;

    // Register views for MTC0 decode and MFC0 readback
    always_comb begin
        wrWord.raw               = cp0Port.writeData;
        srWord.raw               = 32'd0;
        srWord.status.im         = im;
        srWord.status.exl        = exl;
        srWord.status.ie         = ie;
        causeWord.raw            = 32'd0;
        causeWord.cause.bd       = bd;
        causeWord.cause.ip       = ip;
        causeWord.cause.code     = code;
        case (cp0Port.regId)
            `CP0_SR:    cp0Port.readData = srWord.raw;
            `CP0_CAUSE: cp0Port.readData = causeWord.raw;
            `CP0_EPC:   cp0Port.readData = {epcReg, 2'b00};
            `CP0_PRID:  cp0Port.readData = `CP0_PRID_VALUE;
            default:    cp0Port.readData = 32'd0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            im     <= 6'b111111;
            exl    <= 1'b0;
            ie     <= 1'b1;
            ip     <= 6'd0;
            code   <= memStagePkg::excNone;
            bd     <= 1'b0;
            epcReg <= textStart[31:2];
        end else begin
            ip <= hwInt;
            if (trap) begin
                exl    <= 1'b1;
                // Interrupts record code 0
                code   <= interrupt ? memStagePkg::excNone : cp0Port.excIn;
                bd     <= branchInWb;
                // Back up to the branch when in a delay slot
                epcReg <= branchInWb ? pc[31:2] - 30'd1 : pc[31:2];
            end else if (cp0Port.eret) begin
                exl  <= 1'b0;
                code <= memStagePkg::excNone;
                bd   <= 1'b0;
            end else if (cp0Port.writeEn) begin
                if (cp0Port.regId == `CP0_SR) begin
                    im  <= wrWord.status.im;
                    exl <= wrWord.status.exl;
                    ie  <= wrWord.status.ie;
                end else if (cp0Port.regId == `CP0_EPC) begin
                    epcReg <= wrWord.raw[31:2];
                end
            end
        end
    end
endmodule

//--- design/dataMem.sv
`timescale 1ns/1ps
`include "memStage_defines.svh"

module dataMem (
    input logic         clk,
    dataPortIf.memory   dataPort
);
    localparam int idxWidth = $clog2(`MEM_DEPTH_WORDS);
    localparam logic [idxWidth-1:0] lastIdx = idxWidth'(`MEM_DEPTH_WORDS - 1);

    logic [31:0]         mem [0:`MEM_DEPTH_WORDS-1];
    logic [idxWidth-1:0] idx;

    assign idx = dataPort.wordAddr[idxWidth-1:0];

    // Asynchronous read, words past the end read zero
    assign dataPort.readData = (idx <= lastIdx) ? mem[idx] : 32'd0;

    // One write per enabled lane
    always_ff @(posedge clk) begin
        for (int lane = 0; lane < 4; lane++) begin
            if (dataPort.byteEnable[lane]) begin
                mem[idx][8*lane +: 8] <= dataPort.writeData[8*lane +: 8];
            end
        end
    end
endmodule

//--- design/memAccessUnit.sv
`timescale 1ns/1ps
`include "memStage_defines.svh"

module memAccessUnit (
    input  memStagePkg::memOp   op,
    input  logic [31:0]         addr,
    input  logic [31:0]         storeData,
    input  logic                accessEnable,
    dataPortIf.access           dataPort,
    output memStagePkg::excCode memExc,
    output logic [31:0]         loadValue
);
    logic        isLoad;
    logic        isStore;
    logic        misaligned;
    logic        inRange;
    logic [3:0]  laneMask;
    logic [15:0] halfVal;
    logic [7:0]  byteVal;

    assign isLoad  = op inside {memStagePkg::opLw, memStagePkg::opLh, memStagePkg::opLhu,
                                memStagePkg::opLb, memStagePkg::opLbu};
    assign isStore = op inside {memStagePkg::opSw, memStagePkg::opSh, memStagePkg::opSb};

    // Word needs bits 1:0 clear, halfword bit 0
    assign misaligned = ((op == memStagePkg::opLw || op == memStagePkg::opSw) && addr[1:0] != 2'b00)
        || ((op inside {memStagePkg::opLh, memStagePkg::opLhu, memStagePkg::opSh}) && addr[0]);

    // Offset check, single unsigned compare
    assign inRange = (addr - `MEM_DATA_START) <= (`MEM_DATA_END - `MEM_DATA_START);

    always_comb begin
        if (isLoad && (misaligned || !inRange)) begin
            memExc = memStagePkg::excAdEL;
        end else if (isStore && (misaligned || !inRange)) begin
            memExc = memStagePkg::excAdEs;
        end else begin
            memExc = memStagePkg::excNone;
        end
    end

    // Lane placement of store data
    always_comb begin
        case (op)
            memStagePkg::opSw: laneMask = 4'b1111;
            memStagePkg::opSh: laneMask = 4'b0011 << {addr[1], 1'b0};
            memStagePkg::opSb: laneMask = 4'b0001 << addr[1:0];
            default:           laneMask = 4'b0000;
        endcase
        case (op)
            memStagePkg::opSh: dataPort.writeData = {2{storeData[15:0]}};
            memStagePkg::opSb: dataPort.writeData = {4{storeData[7:0]}};
            default:           dataPort.writeData = storeData;
        endcase
    end

    assign dataPort.wordAddr   = addr[31:2];
    assign dataPort.byteEnable = (accessEnable && memExc == memStagePkg::excNone) ? laneMask
                                                                                 : 4'b0000;

    // Load extraction and extension
    assign halfVal = addr[1] ? dataPort.readData[31:16] : dataPort.readData[15:0];
    assign byteVal = dataPort.readData[{addr[1:0], 3'b000} +: 8];

    always_comb begin
        case (op)
            memStagePkg::opLw:  loadValue = dataPort.readData;
            memStagePkg::opLh:  loadValue = {{16{halfVal[15]}}, halfVal};
            memStagePkg::opLhu: loadValue = {16'd0, halfVal};
            memStagePkg::opLb:  loadValue = {{24{byteVal[7]}}, byteVal};
            memStagePkg::opLbu: loadValue = {24'd0, byteVal};
            default:            loadValue = 32'd0;
        endcase
    end
endmodule

//--- design/memCtrl.sv
`timescale 1ns/1ps

module memCtrl (
    input  logic                clk,
    input  logic                reset,
    input  logic                stall,
    input  logic                flush,
    input  memStagePkg::memOp   op,
    input  logic [31:0]         pc,
    input  logic [31:0]         rtData,
    input  logic [4:0]          rtAddr,
    input  logic [4:0]          rdAddr,
    input  logic [4:0]          regWriteAddr,
    input  logic [31:0]         regWriteData,
    input  logic [4:0]          fwdAddr,
    input  logic [31:0]         fwdData,
    input  memStagePkg::excCode excInPrev,
    input  logic                dmDisable,
    input  memStagePkg::excCode memExc,
    input  logic [31:0]         loadValue,
    output logic                accessEnable,
    output logic [31:0]         storeData,
    cp0PortIf.ctrl              cp0Port,
    output logic [4:0]          wbRegAddr,
    output logic [31:0]         wbRegData,
    output logic [31:0]         wbPc
);
    logic        isLoad;
    logic [31:0] wbValue;

    // Writeback value bypass onto rt
    assign storeData = (fwdAddr == rtAddr && fwdAddr != 5'd0) ? fwdData : rtData;

    // Address faults of this stage take priority
    assign cp0Port.excIn = (memExc != memStagePkg::excNone) ? memExc : excInPrev;

    assign cp0Port.writeEn   = (op == memStagePkg::opMtc0);
    assign cp0Port.eret      = (op == memStagePkg::opEret);
    assign cp0Port.regId     = rdAddr;
    assign cp0Port.writeData = storeData;

    // No memory write in a trapped cycle
    assign accessEnable = !dmDisable && !cp0Port.trap;

    assign isLoad = op inside {memStagePkg::opLw, memStagePkg::opLh, memStagePkg::opLhu,
                               memStagePkg::opLb, memStagePkg::opLbu};

    always_comb begin
        if (op == memStagePkg::opMfc0) begin
            wbValue = cp0Port.readData;
        end else if (isLoad) begin
            wbValue = loadValue;
        end else begin
            wbValue = regWriteData;
        end
    end

    // MEM/WB register, flush beats stall
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            wbRegAddr <= 5'd0;
            wbRegData <= 32'd0;
            wbPc      <= 32'd0;
        end else if (!stall) begin
            wbRegAddr <= regWriteAddr;
            wbRegData <= wbValue;
            wbPc      <= pc;
        end
    end
endmodule

//--- design/memStageIf.sv
`timescale 1ns/1ps

// Data RAM port, no handshake
interface dataPortIf;
    logic [29:0] wordAddr;
    logic [31:0] writeData;
    logic [3:0]  byteEnable;
    logic [31:0] readData;

    modport access(output wordAddr, writeData, byteEnable, input readData);
    modport memory(input wordAddr, writeData, byteEnable, output readData);
endinterface

// Control to CP0
interface cp0PortIf;
    logic                 writeEn;
    logic [4:0]           regId;
    logic [31:0]          writeData;
    logic                 eret;
    memStagePkg::excCode  excIn;
    logic [31:0]          readData;
    logic                 trap;

    modport ctrl(output writeEn, regId, writeData, eret, excIn, input readData, trap);
    modport cp0(input writeEn, regId, writeData, eret, excIn, output readData, trap);
endinterface

//--- design/memStagePkg.sv
package memStagePkg;

    // Decoded memory-stage operation
    typedef enum logic [3:0] {
        opNone,
        opLw,
        opLh,
        opLhu,
        opLb,
        opLbu,
        opSw,
        opSh,
        opSb,
        opMfc0,
        opMtc0,
        opEret
    } memOp;

    // Cause.ExcCode values
    typedef logic [4:0] excCode;
    localparam excCode excNone = 5'd0;
    localparam excCode excAdEL = 5'd4;
    localparam excCode excAdEs = 5'd5;

    // Request to the pipeline controller
    typedef enum logic [1:0] {
        kcNone,
        kcEnterKernel,
        kcReturn
    } kernelCtrl;

    // SR layout
    typedef struct packed {
        logic [31:16] rsvdHi;
        logic [15:10] im;
        logic [9:2]   rsvdLo;
        logic         exl;
        logic         ie;
    } cp0StatusView;

    // Cause layout
    typedef struct packed {
        logic         bd;
        logic [30:16] rsvdHi;
        logic [15:10] ip;
        logic [9:7]   rsvdMid;
        excCode       code;
        logic [1:0]   rsvdLo;
    } cp0CauseView;

    typedef union packed {
        cp0StatusView status;
        cp0CauseView  cause;
        logic [31:0]  raw;
    } cp0Word;

endpackage

//--- design/memStageTop.sv
`timescale 1ns/1ps

module memStageTop (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    stall,
    input  logic                    flush,
    input  memStagePkg::memOp       op,
    input  logic [31:0]             pc,
    input  logic [31:0]             aluOut,
    input  logic [31:0]             rtData,
    input  logic [4:0]              rtAddr,
    input  logic [4:0]              rdAddr,
    input  logic [4:0]              regWriteAddr,
    input  logic [31:0]             regWriteData,
    input  logic [4:0]              fwdAddr,
    input  logic [31:0]             fwdData,
    input  memStagePkg::excCode     excInPrev,
    input  logic [5:0]              hwInt,
    input  logic                    branchInWb,
    input  logic                    dmDisable,
    output logic [4:0]              wbRegAddr,
    output logic [31:0]             wbRegData,
    output logic [31:0]             wbPc,
    output memStagePkg::kernelCtrl  kernelCtrl,
    output logic [29:0]             epc,
    output logic                    inDelaySlot
);
    logic                accessEnable;
    logic [31:0]         storeData;
    memStagePkg::excCode memExc;
    logic [31:0]         loadValue;

    dataPortIf dataBus ();
    cp0PortIf  cp0Bus ();

    memCtrl ctrl0 (
        .clk(clk), .reset(reset), .stall(stall), .flush(flush), .op(op), .pc(pc),
        .rtData(rtData), .rtAddr(rtAddr), .rdAddr(rdAddr),
        .regWriteAddr(regWriteAddr), .regWriteData(regWriteData),
        .fwdAddr(fwdAddr), .fwdData(fwdData), .excInPrev(excInPrev),
        .dmDisable(dmDisable), .memExc(memExc), .loadValue(loadValue),
        .accessEnable(accessEnable), .storeData(storeData), .cp0Port(cp0Bus.ctrl),
        .wbRegAddr(wbRegAddr), .wbRegData(wbRegData), .wbPc(wbPc)
    );

    memAccessUnit access0 (
        .op(op), .addr(aluOut), .storeData(storeData), .accessEnable(accessEnable),
        .dataPort(dataBus.access), .memExc(memExc), .loadValue(loadValue)
    );

    dataMem mem0 (.clk(clk), .dataPort(dataBus.memory));

    cp0Unit cp0 (
        .clk(clk), .reset(reset), .pc(pc), .hwInt(hwInt), .branchInWb(branchInWb),
        .cp0Port(cp0Bus.cp0), .kernelCtrl(kernelCtrl), .epc(epc), .inDelaySlot(inDelaySlot)
    );
endmodule

//--- design/memStage_defines.svh
`ifndef MEMSTAGE_DEFINES_SVH
`define MEMSTAGE_DEFINES_SVH

// Data region, the only valid load and store space
`define MEM_DATA_START 32'h0000_0000
`define MEM_DATA_END 32'h0000_2FFF

// Words in the data RAM, 0x3000 bytes
`define MEM_DEPTH_WORDS 3072

// CP0 register numbers as seen in the rd field
`define CP0_SR 5'd12
`define CP0_CAUSE 5'd13
`define CP0_EPC 5'd14
`define CP0_PRID 5'd15

// Processor identification, read only
`define CP0_PRID_VALUE 32'h0001_4C01

// Start of text, EPC value out of reset
`define TEXT_START 32'h0000_3000

`endif

//--- memStageTop.f
+incdir+design
design/memStagePkg.sv
design/memStageIf.sv
design/memCtrl.sv
design/memAccessUnit.sv
design/dataMem.sv
design/cp0Unit.sv
design/memStageTop.sv
sim/clockGen.sv
sim/memStageAssert.sv
sim/memStageTb.sv

//--- runSim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module memStageTb \
    -f memStageTop.f -o memStageSim

# The simulator exits nonzero on $fatal, the log decides the result
./obj_dir/memStageSim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation PASSED" sim.log; then
    exit 0
fi
exit 1

//--- sim/clockGen.sv
`timescale 1ns/1ps

module clockGen (
    output logic clk,
    output logic reset
);
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset held for two rising edges
    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
    end
endmodule

//--- sim/memStageAssert.sv
`timescale 1ns/1ps

module memStageAssert (
    input logic                   clk,
    input logic                   reset,
    input logic                   stall,
    input logic                   flush,
    input memStagePkg::kernelCtrl kernelCtrl,
    input logic [3:0]             byteEnable,
    input logic [4:0]             wbRegAddr,
    input logic [31:0]            wbRegData,
    input logic [31:0]            wbPc
);
    // First cycle out of reset is quiet
    resetQuiet: assert property (@(posedge clk)
        $fell(reset) |-> kernelCtrl == memStagePkg::kcNone)
        else $error("kernelCtrl active right after reset");

    // A trapped cycle never touches memory, address faults included
    noWriteOnTrap: assert property (@(posedge clk) disable iff (reset)
        kernelCtrl == memStagePkg::kcEnterKernel |-> byteEnable == 4'b0000)
        else $error("byte enables set in a trapped cycle");

    stallHolds: assert property (@(posedge clk) disable iff (reset)
        stall && !flush |=> $stable(wbRegAddr) && $stable(wbRegData) && $stable(wbPc))
        else $error("MEM/WB register changed under stall");
endmodule

//--- sim/memStageTb.sv
`timescale 1ns/1ps
`include "memStage_defines.svh"

module memStageTb;
    typedef struct packed {
        memStagePkg::memOp      op;
        logic [31:0]            addr;
        logic [31:0]            rtData;
        logic [4:0]             rtAddr;
        logic [4:0]             fwdAddr;
        logic [31:0]            fwdData;
        logic [4:0]             rdAddr;
        logic [4:0]             regAddr;
        logic [5:0]             hwInt;
        logic                   branchInWb;
        logic                   stall;
        logic                   flush;
        logic [31:0]            pc;
        logic [31:0]            expData;
        logic [4:0]             expWbAddr;
        logic [31:0]            expWbPc;
        memStagePkg::kernelCtrl expKc;
        logic [29:0]            expEpc;
    } stimRow;

    logic clk, reset, stall, flush, branchInWb, dmDisable, inDelaySlot;
    memStagePkg::memOp      op;
    logic [31:0]            pc, aluOut, rtData, regWriteData, fwdData, wbRegData, wbPc;
    logic [4:0]             rtAddr, rdAddr, regWriteAddr, fwdAddr, wbRegAddr;
    memStagePkg::excCode    excInPrev;
    logic [5:0]             hwInt;
    memStagePkg::kernelCtrl kernelCtrl;
    logic [29:0]            epc;

    stimRow      rows[$];
    logic [7:0]  refBytes[int];
    logic [29:0] refEpc;
    logic [31:0] rowPc;
    logic        rowStall, rowFlush;
    logic [4:0]  wbAddrExp;
    logic [31:0] wbDataExp, wbPcExp;
    logic [31:0] lfsrState;

    clockGen clock0 (.clk(clk), .reset(reset));

    memStageTop dut0 (
        .clk(clk), .reset(reset), .stall(stall), .flush(flush), .op(op), .pc(pc),
        .aluOut(aluOut), .rtData(rtData), .rtAddr(rtAddr), .rdAddr(rdAddr),
        .regWriteAddr(regWriteAddr), .regWriteData(regWriteData), .fwdAddr(fwdAddr),
        .fwdData(fwdData), .excInPrev(excInPrev), .hwInt(hwInt), .branchInWb(branchInWb),
        .dmDisable(dmDisable), .wbRegAddr(wbRegAddr), .wbRegData(wbRegData), .wbPc(wbPc),
        .kernelCtrl(kernelCtrl), .epc(epc), .inDelaySlot(inDelaySlot)
    );

    bind memStageTop memStageAssert assert0 (
        .clk(clk), .reset(reset), .stall(stall), .flush(flush), .kernelCtrl(kernelCtrl),
        .byteEnable(dataBus.byteEnable), .wbRegAddr(wbRegAddr), .wbRegData(wbRegData),
        .wbPc(wbPc)
    );

    // Galois LFSR, one step per bit
    task automatic randWord(output logic [31:0] w);
        w = 32'd0;
        for (int b = 0; b < 32; b++) begin
            lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'hB4BC_D35C) : (lfsrState >> 1);
            w = {w[30:0], lfsrState[0]};
        end
    endtask

    // Byte-addressed little-endian memory model
    task automatic refStore(input memStagePkg::memOp sop, input logic [31:0] a,
                            input logic [31:0] d);
        int base;
        base = int'({a[31:2], 2'b00});
        case (sop)
            memStagePkg::opSw: for (int k = 0; k < 4; k++) refBytes[base + k] = d[8*k +: 8];
            memStagePkg::opSh: begin
                refBytes[int'(a)] = d[7:0];
                refBytes[int'(a) + 1] = d[15:8];
            end
            default: refBytes[int'(a)] = d[7:0];
        endcase
    endtask

    function automatic logic [31:0] refLoad(input memStagePkg::memOp lop, input logic [31:0] a);
        int          base;
        logic [15:0] h;
        logic [7:0]  b;
        base = int'({a[31:2], 2'b00});
        h = {refBytes[int'(a) + 1], refBytes[int'(a)]};
        b = refBytes[int'(a)];
        case (lop)
            memStagePkg::opLh:  return {{16{h[15]}}, h};
            memStagePkg::opLhu: return {16'd0, h};
            memStagePkg::opLb:  return {{24{b[7]}}, b};
            memStagePkg::opLbu: return {24'd0, b};
            default: return {refBytes[base + 3], refBytes[base + 2],
                             refBytes[base + 1], refBytes[base]};
        endcase
    endfunction

    task automatic addRow(input memStagePkg::memOp rop, input logic [31:0] a,
                          input logic [31:0] d, input logic [4:0] rtA, input logic [4:0] fwdA,
                          input logic [31:0] fwdD, input logic [4:0] rd, input logic [5:0] irq,
                          input logic bwb, input logic [31:0] mfcValue,
                          input memStagePkg::kernelCtrl kc);
        stimRow      r;
        logic [31:0] stored;
        logic [31:0] trapPc;
        logic [31:0] wbValue;
        stored = (fwdA == rtA && fwdA != 5'd0) ? fwdD : d;
        r = '{rop, a, d, rtA, fwdA, fwdD, rd, rowPc[6:2], irq, bwb, rowStall, rowFlush, rowPc,
              32'd0, 5'd0, 32'd0, kc, 30'd0};
        // Loads and MFC0 return data, everything else passes regWriteData
        wbValue = rowPc;
        if (rop inside {memStagePkg::opLw, memStagePkg::opLh, memStagePkg::opLhu,
                        memStagePkg::opLb, memStagePkg::opLbu}) begin
            wbValue = refLoad(rop, a);
        end else if (rop == memStagePkg::opMfc0) begin
            wbValue = mfcValue;
        end
        // MEM/WB model, flush over stall
        if (rowFlush) begin
            wbAddrExp = 5'd0;
            wbDataExp = 32'd0;
            wbPcExp   = 32'd0;
        end else if (!rowStall) begin
            wbAddrExp = rowPc[6:2];
            wbDataExp = wbValue;
            wbPcExp   = rowPc;
        end
        r.expData   = wbDataExp;
        r.expWbAddr = wbAddrExp;
        r.expWbPc   = wbPcExp;
        if (kc == memStagePkg::kcEnterKernel) begin
            trapPc = bwb ? rowPc - 32'd4 : rowPc;
            refEpc = trapPc[31:2];
        end else if (rop inside {memStagePkg::opSw, memStagePkg::opSh, memStagePkg::opSb}) begin
            refStore(rop, a, stored);
        end else if (rop == memStagePkg::opMtc0 && rd == `CP0_EPC) begin
            refEpc = stored[31:2];
        end
        r.expEpc = refEpc;
        rows.push_back(r);
        rowPc = rowPc + 32'd4;
    endtask

    task automatic memRow(input memStagePkg::memOp rop, input logic [31:0] a,
                          input logic [31:0] d, input memStagePkg::kernelCtrl kc);
        addRow(rop, a, d, 5'd2, 5'd0, 32'd0, 5'd0, 6'd0, 1'b0, 32'd0, kc);
    endtask

    task automatic cp0Row(input memStagePkg::memOp rop, input logic [4:0] rd,
                          input logic [31:0] d, input logic [31:0] mfcValue,
                          input memStagePkg::kernelCtrl kc);
        addRow(rop, 32'd0, d, 5'd2, 5'd0, 32'd0, rd, 6'd0, 1'b0, mfcValue, kc);
    endtask

    task automatic buildTable();
        logic [31:0] w0, w1, w2, w3, w4, w5;
        randWord(w0);
        randWord(w1);
        randWord(w2);
        randWord(w3);
        randWord(w4);
        randWord(w5);
        memRow(memStagePkg::opSw, 32'h100, w0, memStagePkg::kcNone);
        memRow(memStagePkg::opLw, 32'h100, 32'd0, memStagePkg::kcNone);
        memRow(memStagePkg::opSw, 32'h104, w1, memStagePkg::kcNone);
        memRow(memStagePkg::opSh, 32'h106, w2, memStagePkg::kcNone);
        memRow(memStagePkg::opSb, 32'h105, w3, memStagePkg::kcNone);
        memRow(memStagePkg::opLh, 32'h106, 32'd0, memStagePkg::kcNone);
        memRow(memStagePkg::opLhu, 32'h106, 32'd0, memStagePkg::kcNone);
        memRow(memStagePkg::opLb, 32'h105, 32'd0, memStagePkg::kcNone);
        memRow(memStagePkg::opLbu, 32'h107, 32'd0, memStagePkg::kcNone);
        memRow(memStagePkg::opLw, 32'h104, 32'd0, memStagePkg::kcNone);
        // Address faults, each followed by a return
        memRow(memStagePkg::opLw, 32'h101, 32'd0, memStagePkg::kcEnterKernel);
        cp0Row(memStagePkg::opEret, 5'd0, 32'd0, 32'd0, memStagePkg::kcReturn);
        memRow(memStagePkg::opSw, 32'h106, w4, memStagePkg::kcEnterKernel);
        cp0Row(memStagePkg::opEret, 5'd0, 32'd0, 32'd0, memStagePkg::kcReturn);
        memRow(memStagePkg::opSb, 32'h3000, w4, memStagePkg::kcEnterKernel);
        cp0Row(memStagePkg::opEret, 5'd0, 32'd0, 32'd0, memStagePkg::kcReturn);
        memRow(memStagePkg::opLw, 32'h104, 32'd0, memStagePkg::kcNone);
        // CP0 access, IM left with only line 0
        cp0Row(memStagePkg::opMtc0, `CP0_SR, 32'h0000_0401, 32'd0, memStagePkg::kcNone);
        cp0Row(memStagePkg::opMfc0, `CP0_SR, 32'd0, 32'h0000_0401, memStagePkg::kcNone);
        cp0Row(memStagePkg::opMtc0, `CP0_EPC, 32'h0000_4440, 32'd0, memStagePkg::kcNone);
        cp0Row(memStagePkg::opMfc0, `CP0_EPC, 32'd0, 32'h0000_4440, memStagePkg::kcNone);
        cp0Row(memStagePkg::opMfc0, `CP0_PRID, 32'd0, `CP0_PRID_VALUE, memStagePkg::kcNone);
        // Interrupts, masked then enabled on a store in a delay slot
        addRow(memStagePkg::opNone, 32'd0, 32'd0, 5'd2, 5'd0, 32'd0, 5'd0, 6'b000010, 1'b0,
               32'd0, memStagePkg::kcNone);
        addRow(memStagePkg::opSw, 32'h104, w5, 5'd2, 5'd0, 32'd0, 5'd0, 6'b000001, 1'b1,
               32'd0, memStagePkg::kcEnterKernel);
        cp0Row(memStagePkg::opEret, 5'd0, 32'd0, 32'd0, memStagePkg::kcReturn);
        cp0Row(memStagePkg::opMfc0, `CP0_SR, 32'd0, 32'h0000_0401, memStagePkg::kcNone);
        memRow(memStagePkg::opLw, 32'h104, 32'd0, memStagePkg::kcNone);
        // Store data bypass
        addRow(memStagePkg::opSw, 32'h200, w4, 5'd7, 5'd7, w5, 5'd0, 6'd0, 1'b0, 32'd0,
               memStagePkg::kcNone);
        memRow(memStagePkg::opLw, 32'h200, 32'd0, memStagePkg::kcNone);
        addRow(memStagePkg::opSw, 32'h204, w4, 5'd0, 5'd0, w5, 5'd0, 6'd0, 1'b0, 32'd0,
               memStagePkg::kcNone);
        memRow(memStagePkg::opLw, 32'h204, 32'd0, memStagePkg::kcNone);
        // Store under stall, then flush over stall
        rowStall = 1'b1;
        memRow(memStagePkg::opSw, 32'h208, w3, memStagePkg::kcNone);
        rowFlush = 1'b1;
        memRow(memStagePkg::opNone, 32'd0, 32'd0, memStagePkg::kcNone);
        rowStall = 1'b0;
        rowFlush = 1'b0;
        memRow(memStagePkg::opLw, 32'h208, 32'd0, memStagePkg::kcNone);
    endtask

    task automatic checkWord(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("Simulation FAILED");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic checkRegAddr(input logic [4:0] got, input logic [4:0] exp);
        if (got !== exp) begin
            $display("error at %0t ns: wbRegAddr is %0d, expected %0d", $time, got, exp);
            $display("Simulation FAILED");
            $fatal(1, "wbRegAddr mismatch");
        end
    endtask

    task automatic checkFlag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            $display("Simulation FAILED");
            $fatal(1, "flag mismatch");
        end
    endtask

    task automatic checkKernel(input memStagePkg::kernelCtrl got,
                               input memStagePkg::kernelCtrl exp);
        if (got !== exp) begin
            $display("error at %0t ns: kernelCtrl is %s, expected %s", $time, got.name(),
                     exp.name());
            $display("Simulation FAILED");
            $fatal(1, "kernelCtrl mismatch");
        end
    endtask

    task automatic checkEpc(input logic [29:0] got, input logic [29:0] exp);
        if (got !== exp) begin
            $display("error at %0t ns: epc is %h, expected %h", $time, got, exp);
            $display("Simulation FAILED");
            $fatal(1, "epc mismatch");
        end
    endtask

    task automatic applyRow(input stimRow r);
        op         = r.op;
        aluOut     = r.addr;
        rtData     = r.rtData;
        rtAddr     = r.rtAddr;
        fwdAddr    = r.fwdAddr;
        fwdData    = r.fwdData;
        rdAddr     = r.rdAddr;
        hwInt      = r.hwInt;
        branchInWb = r.branchInWb;
        pc         = r.pc;
        regWriteData = r.pc;
        regWriteAddr = r.regAddr;
        stall        = r.stall;
        flush        = r.flush;
    endtask

    // Run limit
    initial begin
        for (int c = 0; c < 2000; c++) begin
            @(posedge clk);
        end
        $display("Timeout: the run did not finish within 2000 cycles");
        $display("Simulation FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        memStagePkg::kernelCtrl kcSeen;
        logic                   delaySeen;
        int                     waitCount;
        stall = 1'b0;
        flush = 1'b0;
        op = memStagePkg::opNone;
        pc = 32'd0;
        aluOut = 32'd0;
        rtData = 32'd0;
        rtAddr = 5'd0;
        rdAddr = 5'd0;
        regWriteAddr = 5'd3;
        regWriteData = 32'd0;
        fwdAddr = 5'd0;
        fwdData = 32'd0;
        excInPrev = memStagePkg::excNone;
        hwInt = 6'd0;
        branchInWb = 1'b0;
        dmDisable = 1'b0;
        lfsrState = 32'd86235;
        rowPc = `TEXT_START;
        rowStall = 1'b0;
        rowFlush = 1'b0;
        wbAddrExp = 5'd0;
        wbDataExp = 32'd0;
        wbPcExp = 32'd0;
        refEpc = 30'(`TEXT_START >> 2);
        buildTable();

        waitCount = 0;
        do begin
            @(negedge clk);
            waitCount++;
            if (waitCount > 20) begin
                $display("Timeout: reset was never released");
                $display("Simulation FAILED");
                $fatal(1, "reset wait expired");
            end
        end while (reset);

        foreach (rows[i]) begin
            applyRow(rows[i]);
            #1;
            kcSeen    = kernelCtrl;
            delaySeen = inDelaySlot;
            @(posedge clk);
            @(negedge clk);
            checkWord("wbRegData", wbRegData, rows[i].expData);
            checkWord("wbPc", wbPc, rows[i].expWbPc);
            checkRegAddr(wbRegAddr, rows[i].expWbAddr);
            checkKernel(kcSeen, rows[i].expKc);
            checkFlag("inDelaySlot", delaySeen,
                      rows[i].expKc == memStagePkg::kcEnterKernel && rows[i].branchInWb);
            checkEpc(epc, rows[i].expEpc);
        end
        $display("Simulation PASSED");
        $finish;
    end
endmodule
